// File: Makefile
# Verilator build and run for the UART command master

VERILATOR ?= verilator
TOP       ?= uart_cmd_tb
FILELIST  ?= uart_cmd_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
PASS_MSG  := RESULT: PASS

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/uart_cmd_master.sv
`timescale 1ns/1ps

module uart_cmd_master #(
  parameter int CLKS_PER_BIT = uart_cmd_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_vld,
  input  uart_cmd_pkg::cmd_t      cmd_in,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output logic                    read_vld,
  output uart_cmd_pkg::read_rsp_s read_rsp
);

  import uart_cmd_pkg::*;

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       rx_vld;
  uart_byte_t rx_byte;
  logic       rx_parity_err;
  logic       rx_frame_err;

  uart_cmd_seq #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_cmd_seq_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_vld       (cmd_vld),
    .cmd_in        (cmd_in),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .read_vld      (read_vld),
    .read_rsp      (read_rsp)
  );

  uart_tx_frame #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_frame #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_frame_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

// File: design/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // ============================================================
  // Widths
  // ============================================================

  typedef logic [15:0] cmd_t;        // {wr, addr[6:0], data[7:0]}
  typedef logic [7:0]  uart_byte_t;
  typedef logic [6:0]  uart_addr_t;

  // ============================================================
  // Command and frame constants
  // ============================================================

  localparam int CMD_WRITE_BIT        = 15;
  localparam int DEFAULT_CLKS_PER_BIT = 434;  // 115200 baud at 50 MHz
  localparam int GAP_BITS             = 2;    // Idle bit times between write frames
  localparam int RSP_TIMEOUT_BITS     = 32;
  localparam int FRAME_BITS           = 11;   // Start, 8 data, parity, stop

  // ============================================================
  // Sequencer state and read result
  // ============================================================

  typedef enum logic [2:0] {
    IDLE,
    SEND_HDR,
    GAP,
    SEND_DATA,
    WAIT_RSP,
    DONE
  } seq_state_e;

  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;
    logic       frame_err;   // Stop bit sampled low
    logic       timeout;     // No response frame arrived
  } read_rsp_s;

endpackage

// File: design/uart_cmd_seq.sv
`timescale 1ns/1ps

module uart_cmd_seq #(
  parameter int CLKS_PER_BIT = uart_cmd_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_vld,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_cmd_pkg::uart_byte_t tx_byte,
  input  logic                     tx_busy,
  input  logic                     rx_vld,
  input  uart_cmd_pkg::uart_byte_t rx_byte,
  input  logic                     rx_parity_err,
  input  logic                     rx_frame_err,
  output logic                     read_vld,
  output uart_cmd_pkg::read_rsp_s  read_rsp
);

  import uart_cmd_pkg::*;

  localparam int GAP_CLKS = GAP_BITS * CLKS_PER_BIT;
  localparam int TMO_CLKS = RSP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TMR_W    = $clog2(TMO_CLKS);

  seq_state_e       state;
  cmd_t             cmd_q;
  uart_addr_t       cmd_addr;
  logic             tx_sent;      // Frame issued in this state
  logic [TMR_W-1:0] tmr;          // Gap and response timer
  logic             hdr_go;
  logic             gap_end;
  logic             frame_done;
  logic             rsp_rx;
  logic             rsp_tmo;

  assign cmd_rdy    = (state == IDLE);
  assign cmd_addr   = cmd_q[14:8];
  assign hdr_go     = (state == SEND_HDR) && !tx_sent && !tx_busy;
  assign gap_end    = (state == GAP) && (tmr == TMR_W'(GAP_CLKS - 1));
  assign frame_done = tx_sent && !tx_start && !tx_busy;
  assign rsp_rx     = (state == WAIT_RSP) && rx_vld;
  // Lands read_vld one timeout after the header's stop bit ends
  assign rsp_tmo    = (state == WAIT_RSP) && !rx_vld && (tmr == TMR_W'(TMO_CLKS - 2));

  // ============================================================
  // Command FSM
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      tx_start <= 1'b0;
      tx_sent  <= 1'b0;
      tmr      <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        IDLE:
          if (cmd_vld)
          begin
            state   <= SEND_HDR;
            tx_sent <= 1'b0;
          end
        SEND_HDR:
          if (hdr_go)
          begin
            tx_start <= 1'b1;
            tx_sent  <= 1'b1;
          end
          else if (frame_done)
          begin
            tx_sent <= 1'b0;
            tmr     <= '0;
            state   <= cmd_q[CMD_WRITE_BIT] ? GAP : WAIT_RSP;
          end
        GAP:
          if (gap_end)
          begin
            tx_start <= 1'b1;             // Data frame leaves right after the gap
            tx_sent  <= 1'b1;
            state    <= SEND_DATA;
          end
          else
            tmr <= tmr + 1'b1;
        SEND_DATA:
          if (frame_done)
          begin
            tx_sent <= 1'b0;
            state   <= IDLE;
          end
        WAIT_RSP:
          if (rsp_rx || rsp_tmo)
          begin
            read_vld <= 1'b1;
            state    <= DONE;
          end
          else
            tmr <= tmr + 1'b1;
        DONE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
    if (hdr_go)
      tx_byte <= {cmd_q[CMD_WRITE_BIT], cmd_addr};
    else if (gap_end)
      tx_byte <= cmd_q[7:0];
    if (rsp_rx)
      read_rsp <= '{data: rx_byte, parity_err: rx_parity_err,
                    frame_err: rx_frame_err, timeout: 1'b0};
    else if (rsp_tmo)
      read_rsp <= '{data: '0, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
  end

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while transmitter busy");

  a_no_wr_rsp: assert property (@(posedge clk) disable iff (!rst_n)
                                read_vld |-> !cmd_q[CMD_WRITE_BIT])
    else $error("read_vld after a write command");

endmodule

// File: design/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int CLKS_PER_BIT = uart_cmd_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output logic                     rx_vld,
  output uart_cmd_pkg::uart_byte_t rx_byte,
  output logic                     rx_parity_err,
  output logic                     rx_frame_err
);

  import uart_cmd_pkg::*;

  localparam int CNT_W    = $clog2(CLKS_PER_BIT);
  localparam int BIT_W    = $clog2(FRAME_BITS);
  localparam int HALF_BIT = CLKS_PER_BIT / 2;
  localparam int PAR_BIT  = FRAME_BITS - 2;
  localparam int STOP_BIT = FRAME_BITS - 1;

  logic [2:0]       rx_sync;      // Two sync stages plus edge history
  logic             rx_s;
  logic             rx_prev;
  logic             active;
  logic [CNT_W-1:0] baud_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             samp;
  uart_byte_t       data_sr;
  logic             par_q;

  assign rx_s    = rx_sync[1];
  assign rx_prev = rx_sync[2];

  // Start bit is checked at half a bit, the rest at mid-bit
  assign samp = active && ((bit_cnt == '0) ? (baud_cnt == CNT_W'(HALF_BIT - 1))
                                           : (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sync <= '1;
    else
      rx_sync <= {rx_sync[1:0], rx};
  end

  // ============================================================
  // Frame control
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_vld   <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!active)
      begin
        if (rx_prev && !rx_s)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end
      else if (samp)
      begin
        baud_cnt <= '0;
        if (bit_cnt == '0 && rx_s)
          active <= 1'b0;               // Glitch, not a start bit
        else if (bit_cnt == BIT_W'(STOP_BIT))
        begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (samp)
    begin
      if (bit_cnt != '0 && bit_cnt < BIT_W'(PAR_BIT))
        data_sr <= {rx_s, data_sr[7:1]};  // LSB arrives first
      if (bit_cnt == BIT_W'(PAR_BIT))
        par_q <= rx_s;
      if (bit_cnt == BIT_W'(STOP_BIT))
      begin
        rx_byte       <= data_sr;
        rx_parity_err <= ^{data_sr, par_q};
        rx_frame_err  <= !rx_s;
      end
    end
  end

  a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_vld |=> !rx_vld)
    else $error("rx_vld held longer than one cycle");

endmodule

// File: design/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int CLKS_PER_BIT = uart_cmd_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    tx_start,
  input  uart_cmd_pkg::uart_byte_t tx_byte,
  output logic                    tx_busy,
  output logic                    tx
);

  import uart_cmd_pkg::*;

  localparam int CNT_W    = $clog2(CLKS_PER_BIT);
  localparam int BIT_W    = $clog2(FRAME_BITS);
  localparam int LAST_BIT = FRAME_BITS - 1;

  logic [CNT_W-1:0]      baud_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-2:0] shreg;     // Bits that follow the start bit
  logic                  bit_tick;
  logic                  load;

  assign bit_tick = tx_busy && (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign load     = !tx_busy && tx_start;

  // ============================================================
  // Bit timing and line driver
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      tx_busy  <= 1'b1;
      tx       <= 1'b0;                 // Start bit
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (bit_tick)
    begin
      baud_cnt <= '0;
      if (bit_cnt == BIT_W'(LAST_BIT))
      begin
        tx_busy <= 1'b0;                // Stop bit has run a full bit time
        tx      <= 1'b1;
      end
      else
      begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else if (tx_busy)
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Stop, even parity, then data LSB first
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, ^tx_byte, tx_byte};
    else if (bit_tick)
      shreg <= {1'b1, shreg[FRAME_BITS-2:1]};
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low while transmitter idle");

endmodule

// File: sim/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb;

  import uart_cmd_pkg::*;

  localparam int B        = 16;       // Clocks per bit for simulation speed
  localparam int CLK_NS   = 40;
  localparam int SEED     = 95628;
  localparam int NUM_CMDS = 60;
  localparam int OMIT_N   = 10;       // Out of 120, about 1 in 12
  localparam int PAR_N    = 15;       // About 1 in 8
  localparam int STOP_N   = 12;       // About 1 in 10
  localparam int CMD_BITS = 2 * FRAME_BITS + GAP_BITS + RSP_TIMEOUT_BITS + 8;
  localparam int WDOG_NS  = 2 * NUM_CMDS * CMD_BITS * B * CLK_NS;

  logic       clk;
  logic       rst_n;
  logic       cmd_vld;
  cmd_t       cmd_in;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_vld;
  read_rsp_s  read_rsp;

  uart_byte_t mem [128];              // Remote register file
  read_rsp_s  rsp_q [$];
  int         errors;
  int         rd_seen;
  logic       in_cmd;
  logic       tx_expect;
  logic       hs_flagged;
  logic       line_flagged;

  uart_cmd_master #(.CLKS_PER_BIT(B)) uart_cmd_master_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_in   (cmd_in),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_vld (read_vld),
    .read_rsp (read_rsp)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // ============================================================
  // Result capture and handshake monitor
  // ============================================================

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (read_vld)
      begin
        rsp_q.push_back(read_rsp);
        rd_seen++;
        in_cmd = 1'b0;
      end
      if (in_cmd && cmd_rdy && !hs_flagged)
      begin
        hs_flagged = 1'b1;
        errors++;
        $display("cmd_rdy went high while a command was still running at %0t", $time);
      end
      if (!tx_expect && !tx && !line_flagged)
      begin
        line_flagged = 1'b1;
        errors++;
        $display("tx went low outside an expected frame at %0t", $time);
      end
    end
  end

  // ============================================================
  // Remote device serial side
  // ============================================================

  // Decodes one frame off tx and leaves ok low if no valid start bit came
  task automatic recv_frame(input string name, input int limit,
                            output uart_byte_t b, output logic ok);
    logic [9:0] bits;
    int         n;
    int         i;
    n  = 0;
    ok = 1'b0;
    b  = '0;
    while (tx && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (tx)
    begin
      errors++;
      $display("%s: no frame appeared on tx", name);
      return;
    end
    repeat (B / 2) @(negedge clk);    // Middle of start bit
    if (tx)
    begin
      errors++;
      $display("%s: start bit on tx was too short", name);
      return;
    end
    for (i = 0; i < 10; i++)
    begin
      repeat (B) @(negedge clk);
      bits[i] = tx;
    end
    repeat (B / 2) @(negedge clk);    // End of stop bit
    b  = bits[7:0];
    ok = 1'b1;
    if (^bits[8:0])
    begin
      errors++;
      $display("%s: frame on tx has wrong even parity", name);
    end
    if (!bits[9])
    begin
      errors++;
      $display("%s: frame on tx has a low stop bit", name);
    end
  endtask

  task automatic send_frame(input uart_byte_t b, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    int          i;
    bits = {!bad_stop, (^b) ^ bad_par, b, 1'b0};
    for (i = 0; i < FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (B) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  // ============================================================
  // Checks
  // ============================================================

  task automatic compare_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic compare_rsp(input string name, input read_rsp_s exp, input read_rsp_s act);
    string exp_s;
    string act_s;
    if (act !== exp)
    begin
      exp_s = $sformatf("data 0x%02h par %0b frm %0b tmo %0b",
                        exp.data, exp.parity_err, exp.frame_err, exp.timeout);
      act_s = $sformatf("data 0x%02h par %0b frm %0b tmo %0b",
                        act.data, act.parity_err, act.frame_err, act.timeout);
      errors++;
      $display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
    end
  endtask

  task automatic wait_ready(input string name, input int limit);
    int n;
    n = 0;
    while (!cmd_rdy && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
    begin
      errors++;
      $display("%s: cmd_rdy did not return after the command", name);
    end
  endtask

  // ============================================================
  // Stimulus
  // ============================================================

  initial
  begin
    uart_byte_t hdr;
    uart_byte_t dat;
    uart_byte_t wr_data;
    uart_addr_t addr;
    logic       is_wr;
    logic       ok;
    logic       bad_par;
    logic       bad_stop;
    int         fault;
    int         delay;
    int         n;
    int         idx;
    int         err_start;
    int         pass_cnt;
    int         fail_cnt;
    int         reads;
    string      name;
    read_rsp_s  exp_rsp;
    read_rsp_s  got;

    void'($urandom(SEED));
    rst_n        = 1'b0;
    cmd_vld      = 1'b0;
    cmd_in       = '0;
    rx           = 1'b1;
    errors       = 0;
    rd_seen      = 0;
    in_cmd       = 1'b0;
    tx_expect    = 1'b0;
    hs_flagged   = 1'b0;
    line_flagged = 1'b0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    reads        = 0;
    for (idx = 0; idx < 128; idx++)
      mem[idx] = uart_byte_t'($urandom);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (idx = 0; idx < NUM_CMDS; idx++)
    begin
      is_wr     = 1'($urandom);
      addr      = uart_addr_t'($urandom);
      wr_data   = uart_byte_t'($urandom);
      name      = $sformatf("%s%0d", is_wr ? "wr" : "rd", idx);
      err_start = errors;
      cmd_in    = {is_wr, addr, wr_data};
      cmd_vld   = 1'b1;               // cmd_rdy is high here
      tx_expect = 1'b1;
      @(negedge clk);
      cmd_vld      = 1'b0;
      in_cmd       = 1'b1;
      hs_flagged   = 1'b0;
      line_flagged = 1'b0;
      recv_frame(name, 4 * B, hdr, ok);
      compare_byte({name, " header"}, {is_wr, addr}, hdr);
      if (is_wr)
      begin
        recv_frame(name, (GAP_BITS + 2) * B, dat, ok);
        compare_byte({name, " data"}, wr_data, dat);
        if (ok)
          mem[hdr[6:0]] = dat;
        tx_expect = 1'b0;
        in_cmd    = 1'b0;
      end
      else
      begin
        tx_expect = 1'b0;
        reads++;
        fault    = $urandom_range(119, 0);
        delay    = $urandom_range(8, 0);
        bad_par  = (fault >= OMIT_N) && (fault < OMIT_N + PAR_N);
        bad_stop = (fault >= OMIT_N + PAR_N) && (fault < OMIT_N + PAR_N + STOP_N);
        exp_rsp.data       = mem[hdr[6:0]];
        exp_rsp.parity_err = bad_par;
        exp_rsp.frame_err  = bad_stop;
        exp_rsp.timeout    = 1'b0;
        if (fault < OMIT_N)
        begin
          exp_rsp.data    = '0;     // No response frame at all
          exp_rsp.timeout = 1'b1;
        end
        else
        begin
          repeat (delay * B) @(negedge clk);
          send_frame(mem[hdr[6:0]], bad_par, bad_stop);
        end
        n = 0;
        while (rsp_q.size() == 0 && n < (RSP_TIMEOUT_BITS + 4) * B)
        begin
          @(negedge clk);
          n++;
        end
        if (rsp_q.size() == 0)
        begin
          errors++;
          in_cmd = 1'b0;
          $display("%s: no read_vld came for the read command", name);
        end
        else
        begin
          got = rsp_q.pop_front();
          compare_rsp(name, exp_rsp, got);
        end
      end
      wait_ready(name, 4 * B);
      if (is_wr && rsp_q.size() != 0)
      begin
        errors++;
        $display("%s: read_vld appeared for a write command", name);
        rsp_q.delete();
      end
      if (errors == err_start)
      begin
        pass_cnt++;
        $display("%s addr 0x%02h: ok", name, addr);
      end
      else
      begin
        fail_cnt++;
        $display("%s addr 0x%02h: FAILED", name, addr);
      end
    end

    repeat (2 * B) @(negedge clk);    // Let any stray read_vld show up
    if (rd_seen != reads)
    begin
      errors++;
      $display("read_vld seen %0d times for %0d read commands", rd_seen, reads);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_CMDS, pass_cnt, fail_cnt, errors);
    if (fail_cnt == 0 && errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(WDOG_NS);
    $display("watchdog expired after %0d ns with commands still running", WDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: uart_cmd_master.f
design/uart_cmd_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_seq.sv
design/uart_cmd_master.sv
sim/uart_cmd_tb.sv
